//--- files.f
vred_pkg.sv
lane_valid_gen.sv
vred_ctrl.sv
lane_accum.sv
cross_lane_reduce.sv
vred_top.sv
vred_props.sv
vred_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the vred testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f files.f --top-module vred_tb -o vred_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

sim_out=$(./obj_dir/vred_sim)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "Test OK" <<< "$sim_out"; then
    exit 0
fi
exit 1

//--- vred_tb.sv
`timescale 1ns/1ps

module vred_tb;

    localparam int VLANE_NUM       = 8;
    localparam int MAX_VL_PER_LANE = 256;
    localparam int VL_W            = $clog2(VLANE_NUM*MAX_VL_PER_LANE);
    // beats over all tests, extra beats included
    localparam int TOTAL_BEATS     = 9 + 2 + 26 + 1 + 13 + 10;
    localparam int WATCHDOG_CYCLES = TOTAL_BEATS*4 + 2000;
    localparam int DONE_LIMIT      = 100;

    logic                             clk_i;
    logic                             rst_i;
    logic                             start_i;
    logic [VL_W-1:0]                  vl_i;
    logic                             elem_valid_i;
    vred_pkg::elem_t [VLANE_NUM-1:0]  elem_i;
    logic                             busy_o;
    logic                             done_o;
    vred_pkg::sum_t                   sum_o;

    int seed = 32'h7b7c;
    int errors = 0;
    int checks = 0;

    // every element sent in the current test, beat major
    logic [15:0] elems[$];

    vred_top vred_top_i (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .start_i      (start_i),
        .vl_i         (vl_i),
        .elem_valid_i (elem_valid_i),
        .elem_i       (elem_i),
        .busy_o       (busy_o),
        .done_o       (done_o),
        .sum_o        (sum_o)
    );

    always #20 clk_i = ~clk_i;

    // reference sum, first vl elements modulo 2^32
    function automatic logic [31:0] model_sum(input int vl);
        logic [31:0] acc;
        acc = '0;
        for (int k = 0; k < vl; k++) begin
            acc = acc + 32'(elems[k]);
        end
        return acc;
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        checks++;
        assert (act == exp) else begin
            $display("ERR %s: expected %0h, actual %0h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_reset();
        @(negedge clk_i);
        check_value("reset busy_o", 32'd0, 32'(busy_o));
        check_value("reset done_o", 32'd0, 32'(done_o));
        check_value("reset sum_o", 32'd0, sum_o);
    endtask

    // start a vector, stream its beats plus extra ones, wait for done
    // restart_beat pulses a second start with another vl on that beat
    task automatic run_vector(input string name, input int vl, input int extra,
                              input int max_gap, input int restart_beat);
        int          beats;
        int          gap;
        int          cycles;
        logic [31:0] exp_sum;
        beats = vl / VLANE_NUM + 1;
        elems.delete();
        @(posedge clk_i);
        #2;
        start_i = 1'b1;
        vl_i    = VL_W'(vl);
        @(posedge clk_i);
        #2;
        start_i = 1'b0;
        // busy from the cycle after start
        check_value({name, " start busy"}, 32'd1, 32'(busy_o));
        for (int b = 0; b < beats + extra; b++) begin
            for (int l = 0; l < VLANE_NUM; l++) begin
                elem_i[l] = 16'($random(seed));
                // beats past the last one carry nonzero data
                if (b >= beats) begin
                    elem_i[l][0] = 1'b1;
                end
                elems.push_back(elem_i[l]);
            end
            elem_valid_i = 1'b1;
            if (b == restart_beat) begin
                start_i = 1'b1;
                vl_i    = VL_W'(vl + 16);
            end
            @(posedge clk_i);
            #2;
            elem_valid_i = 1'b0;
            start_i      = 1'b0;
            if (max_gap > 0 && b < beats + extra - 1) begin
                gap = $unsigned($random(seed)) % (max_gap + 1);
                repeat (gap) begin
                    @(posedge clk_i);
                    #2;
                end
            end
        end
        cycles = 0;
        do begin
            @(negedge clk_i);
            cycles++;
        end while (!done_o && cycles < DONE_LIMIT);
        if (!done_o) begin
            $display("%s: done_o never went high after the last beat", name);
            errors++;
        end else begin
            exp_sum = model_sum(vl);
            check_value(name, exp_sum, sum_o);
            // latency only holds when the last beat ends the stream
            if (extra == 0) begin
                check_value({name, " latency"}, 32'(VLANE_NUM + 1), 32'(cycles));
            end
            @(negedge clk_i);
            check_value({name, " hold"}, exp_sum, sum_o);
            // back to idle once done is left
            check_value({name, " idle busy"}, 32'd0, 32'(busy_o));
        end
    endtask

    initial begin
        clk_i        = 1'b0;
        rst_i        = 1'b0;
        start_i      = 1'b0;
        vl_i         = '0;
        elem_valid_i = 1'b0;
        elem_i       = '0;
        repeat (3) @(posedge clk_i);
        #2;
        rst_i = 1'b1;
        check_reset();
        run_vector("whole_groups", 64, 0, 0, -1);
        run_vector("short_vector", 5, 1, 0, -1);
        run_vector("ragged_tail", 203, 0, 0, -1);
        run_vector("zero_length", 0, 0, 0, -1);
        run_vector("beat_gaps", 100, 0, 3, -1);
        run_vector("busy_restart", 77, 0, 0, 4);
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    // ends a hung run
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk_i);
        $display("timeout: tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Test FAILED");
        $finish;
    end

endmodule

//--- vred_props.sv
`timescale 1ns/1ps

module vred_props #(
    parameter int VLANE_NUM = 8
) (
    input logic                clk_i,
    input logic                rst_i,
    input logic                start_i,
    input logic                busy_i,
    input logic                done_i,
    input vred_pkg::vred_cmd_t cmd_i,
    input logic                last_beat_i
);

    // done is one cycle wide
    done_pulse: assert property (@(posedge clk_i) disable iff (!rst_i)
        done_i |=> !done_i)
        else $error("done_o high for more than one cycle");

    // snap plus VLANE_NUM-1 folds plus done
    done_latency: assert property (@(posedge clk_i) disable iff (!rst_i)
        (cmd_i.shift_en && last_beat_i) |-> ##(VLANE_NUM + 1) done_i)
        else $error("done_o not VLANE_NUM+1 cycles after the last beat");

    // a start is taken only while idle
    load_idle: assert property (@(posedge clk_i) disable iff (!rst_i)
        cmd_i.load |-> (!busy_i && !done_i))
        else $error("load issued while busy or done");

    // a start seen in idle makes the unit busy next cycle
    start_taken: assert property (@(posedge clk_i) disable iff (!rst_i)
        (start_i && !busy_i) |=> busy_i)
        else $error("start in idle did not make the unit busy");

    // never two commands at once
    cmd_onehot: assert property (@(posedge clk_i) disable iff (!rst_i)
        $onehot0({cmd_i.load, cmd_i.shift_en, cmd_i.shift_partial}))
        else $error("more than one command bit set");

endmodule

bind vred_top vred_props #(
    .VLANE_NUM (VLANE_NUM)
) vred_props_i (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .start_i     (start_i),
    .busy_i      (busy_o),
    .done_i      (done_o),
    .cmd_i       (cmd),
    .last_beat_i (last_beat)
);

//--- vred_top.sv
`timescale 1ns/1ps

module vred_top #(
    parameter int VLANE_NUM       = 8,
    parameter int MAX_VL_PER_LANE = 256
) (
    input  logic                                         clk_i,
    input  logic                                         rst_i,
    input  logic                                         start_i,
    input  logic [$clog2(VLANE_NUM*MAX_VL_PER_LANE)-1:0] vl_i,
    input  logic                                         elem_valid_i,
    input  vred_pkg::elem_t [VLANE_NUM-1:0]              elem_i,
    output logic                                         busy_o,
    output logic                                         done_o,
    output vred_pkg::sum_t                               sum_o
);

    // controller commands, shared by all stages
    vred_pkg::vred_cmd_t cmd;
    logic                snap;

    // mask block outputs
    logic [VLANE_NUM-1:0] lane_valid;
    logic                 last_beat;
    logic                 partial_valid;

    // per-lane partial sums
    vred_pkg::sum_t [VLANE_NUM-1:0] lane_sum;

    vred_ctrl #(
        .VLANE_NUM (VLANE_NUM)
    ) vred_ctrl_i (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .start_i      (start_i),
        .elem_valid_i (elem_valid_i),
        .last_beat_i  (last_beat),
        .cmd_o        (cmd),
        .snap_o       (snap),
        .busy_o       (busy_o),
        .done_o       (done_o)
    );

    lane_valid_gen #(
        .VLANE_NUM       (VLANE_NUM),
        .MAX_VL_PER_LANE (MAX_VL_PER_LANE)
    ) lane_valid_gen_i (
        .clk_i           (clk_i),
        .rst_i           (rst_i),
        .vl_i            (vl_i),
        .cmd_i           (cmd),
        .valid_o         (lane_valid),
        .last_beat_o     (last_beat),
        .partial_valid_o (partial_valid)
    );

    lane_accum #(
        .VLANE_NUM (VLANE_NUM)
    ) lane_accum_i (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .cmd_i        (cmd),
        .lane_valid_i (lane_valid),
        .elem_i       (elem_i),
        .lane_sum_o   (lane_sum)
    );

    cross_lane_reduce #(
        .VLANE_NUM (VLANE_NUM)
    ) cross_lane_reduce_i (
        .clk_i           (clk_i),
        .rst_i           (rst_i),
        .cmd_i           (cmd),
        .snap_i          (snap),
        .lane_sum_i      (lane_sum),
        .partial_valid_i (partial_valid),
        .sum_o           (sum_o)
    );

endmodule

//--- cross_lane_reduce.sv
`timescale 1ns/1ps

module cross_lane_reduce #(
    parameter int VLANE_NUM = 8
) (
    input  logic                            clk_i,
    input  logic                            rst_i,
    input  vred_pkg::vred_cmd_t             cmd_i,
    input  logic                            snap_i,
    input  vred_pkg::sum_t [VLANE_NUM-1:0]  lane_sum_i,
    input  logic                            partial_valid_i,
    output vred_pkg::sum_t                  sum_o
);

    // running sum, starts from lane 0
    vred_pkg::sum_t sum_q;

    // lanes 1 and up, entry 0 is the next lane to fold
    vred_pkg::sum_t [VLANE_NUM-2:0] lane_sr;

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            sum_q <= '0;
        end else if (cmd_i.load) begin
            sum_q <= '0;
        end else if (snap_i) begin
            sum_q <= lane_sum_i[0];
        end else if (cmd_i.shift_partial && partial_valid_i) begin
            // lanes past vl are skipped
            sum_q <= sum_q + lane_sr[0];
        end
    end

    // fold register, only meaningful between snap and done
    always_ff @(posedge clk_i) begin
        if (snap_i) begin
            for (int i = 0; i < VLANE_NUM - 1; i++) begin
                lane_sr[i] <= lane_sum_i[i+1];
            end
        end else if (cmd_i.shift_partial) begin
            for (int i = 0; i < VLANE_NUM - 2; i++) begin
                lane_sr[i] <= lane_sr[i+1];
            end
            lane_sr[VLANE_NUM-2] <= '0;
        end
    end

    // held from done until the next load
    assign sum_o = sum_q;

endmodule

//--- lane_accum.sv
`timescale 1ns/1ps

module lane_accum #(
    parameter int VLANE_NUM = 8
) (
    input  logic                                clk_i,
    input  logic                                rst_i,
    input  vred_pkg::vred_cmd_t                 cmd_i,
    input  logic [VLANE_NUM-1:0]                lane_valid_i,
    input  vred_pkg::elem_t [VLANE_NUM-1:0]     elem_i,
    output vred_pkg::sum_t [VLANE_NUM-1:0]      lane_sum_o
);

    vred_pkg::sum_t [VLANE_NUM-1:0] acc_q;
    vred_pkg::sum_t [VLANE_NUM-1:0] acc_d;

    // masked add per lane
    // unsigned elements, zero extended to the sum width
    always_comb begin
        for (int i = 0; i < VLANE_NUM; i++) begin
            if (cmd_i.shift_en && lane_valid_i[i]) begin
                acc_d[i] = acc_q[i] + vred_pkg::sum_t'(elem_i[i]);
            end else begin
                acc_d[i] = acc_q[i];
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            acc_q <= '0;
        end else if (cmd_i.load) begin
            // new vector starts from zero in every lane
            acc_q <= '0;
        end else begin
            acc_q <= acc_d;
        end
    end

    assign lane_sum_o = acc_q;

endmodule

//--- vred_ctrl.sv
`timescale 1ns/1ps

module vred_ctrl #(
    parameter int VLANE_NUM = 8
) (
    input  logic                clk_i,
    input  logic                rst_i,
    input  logic                start_i,
    input  logic                elem_valid_i,
    input  logic                last_beat_i,
    output vred_pkg::vred_cmd_t cmd_o,
    output logic                snap_o,
    output logic                busy_o,
    output logic                done_o
);

    // fold step counter width, counts 0 to VLANE_NUM-2
    localparam int FCNT_W = (VLANE_NUM > 2) ? $clog2(VLANE_NUM - 1) : 1;

    vred_pkg::vred_state_e state_q;
    vred_pkg::vred_state_e state_d;

    logic [FCNT_W-1:0] fold_cnt;
    logic              fold_last;

    assign fold_last = (fold_cnt == FCNT_W'(VLANE_NUM - 2));

    // commands decode straight from state and strobes
    // load must land in the start cycle so vl_i is seen
    always_comb begin
        cmd_o.load          = (state_q == vred_pkg::IDLE) & start_i;
        cmd_o.shift_en      = (state_q == vred_pkg::ACCUM) & elem_valid_i;
        cmd_o.shift_partial = (state_q == vred_pkg::FOLD);
    end

    assign snap_o = (state_q == vred_pkg::SNAP);
    assign busy_o = (state_q != vred_pkg::IDLE);
    assign done_o = (state_q == vred_pkg::DONE);

    // next state
    always_comb begin
        state_d = state_q;
        case (state_q)
            vred_pkg::IDLE: begin
                if (start_i) begin
                    state_d = vred_pkg::ACCUM;
                end
            end
            vred_pkg::ACCUM: begin
                // vl is not known here, last beat comes from the mask block
                if (elem_valid_i && last_beat_i) begin
                    state_d = vred_pkg::SNAP;
                end
            end
            vred_pkg::SNAP: begin
                state_d = vred_pkg::FOLD;
            end
            vred_pkg::FOLD: begin
                if (fold_last) begin
                    state_d = vred_pkg::DONE;
                end
            end
            vred_pkg::DONE: begin
                state_d = vred_pkg::IDLE;
            end
            default: begin
                state_d = vred_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            state_q <= vred_pkg::IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // VLANE_NUM-1 fold steps
    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            fold_cnt <= '0;
        end else if (state_q == vred_pkg::SNAP) begin
            fold_cnt <= '0;
        end else if (state_q == vred_pkg::FOLD && !fold_last) begin
            fold_cnt <= fold_cnt + 1'b1;
        end
    end

endmodule

//--- lane_valid_gen.sv
`timescale 1ns/1ps

module lane_valid_gen #(
    parameter int VLANE_NUM       = 8,
    parameter int MAX_VL_PER_LANE = 256
) (
    input  logic                                         clk_i,
    input  logic                                         rst_i,
    input  logic [$clog2(VLANE_NUM*MAX_VL_PER_LANE)-1:0] vl_i,
    input  vred_pkg::vred_cmd_t                          cmd_i,
    output logic [VLANE_NUM-1:0]                         valid_o,
    output logic                                         last_beat_o,
    output logic                                         partial_valid_o
);

    localparam int LANE_W = $clog2(VLANE_NUM);
    localparam int BEAT_W = $clog2(MAX_VL_PER_LANE);

    // vl split into whole groups and leftover lanes
    logic [BEAT_W-1:0]    div_in;
    logic [LANE_W-1:0]    mod_in;
    logic [VLANE_NUM-1:0] tail_in;

    // held across the whole vector, vl_i is only valid on load
    logic [BEAT_W-1:0]    div_q;
    logic [BEAT_W-1:0]    beat_cnt;
    logic [VLANE_NUM-1:0] tail_q;
    // bit 0 is lane 1, bit 1 is lane 2 and so on
    logic [VLANE_NUM-2:0] partial_q;

    logic                 at_tail;
    logic [VLANE_NUM-1:0] beat_mask;

    assign mod_in = vl_i[LANE_W-1:0];
    assign div_in = BEAT_W'(vl_i >> LANE_W);

    // tail mask, lanes below mod
    always_comb begin
        tail_in = '0;
        for (int i = 0; i < VLANE_NUM; i++) begin
            if (i < int'(mod_in)) begin
                tail_in[i] = 1'b1;
            end
        end
    end

    assign at_tail = (beat_cnt == div_q);

    // full groups before beat div, tail at div
    // tail_q is cleared once the tail beat is taken
    always_comb begin
        if (at_tail) begin
            beat_mask = tail_q;
        end else begin
            beat_mask = '1;
        end
    end

    assign valid_o         = beat_mask & {VLANE_NUM{cmd_i.shift_en}};
    assign last_beat_o     = cmd_i.shift_en & at_tail;
    assign partial_valid_o = partial_q[0];

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            div_q     <= '0;
            beat_cnt  <= '0;
            tail_q    <= '0;
            partial_q <= '0;
        end else if (cmd_i.load) begin
            div_q    <= div_in;
            beat_cnt <= '0;
            tail_q   <= tail_in;
            // with a full group present every lane holds data
            if (div_in != '0) begin
                partial_q <= '1;
            end else begin
                partial_q <= tail_in[VLANE_NUM-1:1];
            end
        end else if (cmd_i.shift_en) begin
            if (at_tail) begin
                // beats after the tail see an empty mask
                tail_q <= '0;
            end else begin
                beat_cnt <= beat_cnt + 1'b1;
            end
        end else if (cmd_i.shift_partial) begin
            // moves in step with the fold register
            partial_q <= partial_q >> 1;
        end
    end

endmodule

//--- vred_pkg.sv
package vred_pkg;

    // one vector element as it arrives on a lane
    typedef logic [15:0] elem_t;

    // lane accumulator and final reduction result
    // wraps modulo 2^32
    typedef logic [31:0] sum_t;

    // per-cycle commands from the controller
    // at most one bit is set in any cycle
    typedef struct packed {
        // start of a new vector, vl sampled here
        logic load;
        // element beat accepted this cycle
        logic shift_en;
        // one cross-lane fold step
        logic shift_partial;
    } vred_cmd_t;

    // controller states
    typedef enum logic [2:0] {
        // waiting for start
        IDLE  = 3'd0,
        // taking element beats
        ACCUM = 3'd1,
        // lane sums copied into the fold register
        SNAP  = 3'd2,
        // one lane folded per cycle
        FOLD  = 3'd3,
        // result valid for one cycle
        DONE  = 3'd4
    } vred_state_e;

endpackage
